/* vlog.f */
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_rx_fifo.sv
rtl/uart_core.sv
verification/uart_line_model.sv
verification/uart_core_tb.sv

/* Bender.yml */
package:
  name: uart_core

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_tx.sv
  - rtl/uart_rx.sv
  - rtl/uart_rx_fifo.sv
  - rtl/uart_core.sv
  - target: simulation
    files:
      - verification/uart_line_model.sv
      - verification/uart_core_tb.sv

/* verification/uart_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core_tb;
  import uart_pkg::*;

  localparam int CLOCK_FREQ = 250_000_000;
  localparam int BAUD_RATE  = 15_625_000;
  localparam int FIFO_DEPTH = 8;
  localparam int BIT_CLKS   = 16;
  // About 60 frames of 11 line bits, plus half again
  localparam int MAX_CYCLES = 60 * 11 * BIT_CLKS * 3 / 2;

  typedef uart_byte_t byte_q_t[$];

  logic        clk;
  logic        rst_n;
  logic        utx_valid;
  uart_byte_t  utx_data;
  logic        utx_ready;
  logic        urx_valid;
  uart_byte_t  urx_data;
  logic        urx_ready;
  logic        frame_err;
  logic        overrun;
  logic        utx_pin;
  logic        urx_pin;

  logic [31:0] rng;
  byte_q_t     rx_got;
  byte_q_t     tx_sent;
  byte_q_t     line_sent;
  byte_q_t     tx_plan;
  byte_q_t     line_plan;
  int          ferr_cnt;
  int          ovr_cnt;
  int          cycles;
  int          errors;
  int          errs_at_start;
  int          tests_passed;
  int          tests_failed;

  uart_core #(
    .CLOCK_FREQ(CLOCK_FREQ),
    .BAUD_RATE (BAUD_RATE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready),
    .frame_err(frame_err),
    .overrun  (overrun),
    .utx_pin  (utx_pin),
    .urx_pin  (urx_pin)
  );

  uart_line_model #(
    .BIT_CLKS(BIT_CLKS)
  ) line0 (
    .clk   (clk),
    .tx_pin(utx_pin),
    .rx_pin(urx_pin)
  );

  always #2 clk = ~clk;

  // Collects every urx transfer and counts the status pulses
  always @(posedge clk) begin
    if (rst_n) begin
      if (urx_valid && urx_ready) begin
        rx_got.push_back(urx_data);
      end
      if (frame_err) begin
        ferr_cnt++;
      end
      if (overrun) begin
        ovr_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function uart_byte_t rand_byte();
    rng = xorshift32(rng);
    return rng[7:0];
  endfunction

  // Ready reader gets every byte, a reader stalled for the whole burst
  // gets only the first FIFO_DEPTH of them
  function automatic byte_q_t expected_rx(input byte_q_t sent, input logic stalled);
    byte_q_t exp_q;
    foreach (sent[i]) begin
      if (!stalled || i < FIFO_DEPTH) begin
        exp_q.push_back(sent[i]);
      end
    end
    return exp_q;
  endfunction

  task automatic compare_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic verify_pulses(input string name, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("MISMATCH %s pulses: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Tester stays 0.5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic send_tx(input uart_byte_t b);
    utx_valid = 1'b1;
    utx_data  = b;
    @(posedge clk);
    while (!utx_ready) begin
      @(posedge clk);
    end
    #0.5;
    utx_valid = 1'b0;
    tx_sent.push_back(b);
  endtask

  task automatic send_line(input uart_byte_t b);
    line0.send_byte(b);
    line_sent.push_back(b);
  endtask

  task automatic wait_rx(input int n);
    while (rx_got.size() < n) begin
      next_cycle();
    end
    // Extra bytes would show up here
    repeat (2 * BIT_CLKS) next_cycle();
  endtask

  task automatic compare_rx(input byte_q_t exp_q);
    if (rx_got.size() != exp_q.size()) begin
      errors++;
      $display("urx delivered %0d bytes where %0d were expected", rx_got.size(), exp_q.size());
    end
    foreach (exp_q[i]) begin
      if (i < rx_got.size()) begin
        compare_byte($sformatf("urx_data[%0d]", i), rx_got[i], exp_q[i]);
      end
    end
  endtask

  // Decoded TX frames against the bytes handed to utx
  task automatic compare_tx();
    uart_byte_t b;
    logic       stop_ok;
    while (line0.frames_waiting() < tx_sent.size()) begin
      next_cycle();
    end
    foreach (tx_sent[i]) begin
      line0.pop_frame(b, stop_ok);
      compare_byte($sformatf("utx_pin byte %0d", i), b, tx_sent[i]);
      check_level($sformatf("utx_pin stop bit %0d", i), stop_ok, 1'b1);
    end
  endtask

  task automatic start_test();
    rx_got.delete();
    tx_sent.delete();
    line_sent.delete();
    ferr_cnt      = 0;
    ovr_cnt       = 0;
    errs_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_at_start);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    utx_valid    = 1'b0;
    utx_data     = '0;
    urx_ready    = 1'b1;
    rng          = 32'd68018;
    cycles       = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    start_test();
    repeat (4) next_cycle();
    check_level("utx_pin", utx_pin, 1'b1);
    check_level("utx_ready", utx_ready, 1'b1);
    check_level("urx_valid", urx_valid, 1'b0);
    verify_pulses("frame_err", ferr_cnt, 0);
    verify_pulses("overrun", ovr_cnt, 0);
    end_test("reset state");

    start_test();
    repeat (16) send_tx(rand_byte());
    compare_tx();
    end_test("transmit");

    start_test();
    repeat (16) send_line(rand_byte());
    wait_rx(16);
    compare_rx(expected_rx(line_sent, 1'b0));
    end_test("receive");

    // Good byte, broken stop bit, good byte
    start_test();
    send_line(rand_byte());
    line0.send_bad_frame(rand_byte());
    send_line(rand_byte());
    wait_rx(2);
    verify_pulses("frame_err", ferr_cnt, 1);
    verify_pulses("overrun", ovr_cnt, 0);
    compare_rx(expected_rx(line_sent, 1'b0));
    end_test("framing error");

    // Reader stalled while the FIFO overflows by three
    start_test();
    next_cycle();
    urx_ready = 1'b0;
    repeat (FIFO_DEPTH + 3) send_line(rand_byte());
    repeat (BIT_CLKS) next_cycle();
    verify_pulses("overrun", ovr_cnt, 3);
    urx_ready = 1'b1;
    wait_rx(FIFO_DEPTH);
    compare_rx(expected_rx(line_sent, 1'b1));
    end_test("overrun");

    // Both directions at once, bytes drawn up front
    start_test();
    tx_plan.delete();
    line_plan.delete();
    repeat (8) begin
      tx_plan.push_back(rand_byte());
      line_plan.push_back(rand_byte());
    end
    fork
      foreach (tx_plan[i]) begin
        send_tx(tx_plan[i]);
      end
      foreach (line_plan[j]) begin
        send_line(line_plan[j]);
      end
    join
    next_cycle();
    wait_rx(8);
    compare_tx();
    compare_rx(expected_rx(line_sent, 1'b0));
    verify_pulses("frame_err", ferr_cnt, 0);
    verify_pulses("overrun", ovr_cnt, 0);
    end_test("full duplex");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/uart_line_model.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_line_model #(
  parameter int BIT_CLKS = 16
) (
  input  logic clk,
  input  logic tx_pin,
  output logic rx_pin
);
  import uart_pkg::*;

  // Frames decoded from the TX pin, with their stop-bit level
  uart_byte_t dec_q[$];
  logic       stop_q[$];
  uart_byte_t dec_byte;
  logic       dec_stop;

  // RX line rests high
  initial rx_pin = 1'b1;

  // Decoder samples on the falling clock edge, away from the DUT's updates
  always begin
    @(negedge tx_pin);
    // Half a bit to the middle of the start bit
    repeat (BIT_CLKS / 2) @(negedge clk);
    if (tx_pin === 1'b0) begin
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        dec_byte[i] = tx_pin;
      end
      repeat (BIT_CLKS) @(negedge clk);
      dec_stop = tx_pin;
      dec_q.push_back(dec_byte);
      stop_q.push_back(dec_stop);
    end
  end

  function int frames_waiting();
    return dec_q.size();
  endfunction

  task automatic pop_frame(output uart_byte_t b, output logic stop_ok);
    b       = dec_q.pop_front();
    stop_ok = stop_q.pop_front();
  endtask

  // One bit held for exactly BIT_CLKS cycles, changed just after the edge
  task automatic drive_bit(input logic level);
    @(posedge clk);
    #0.5;
    rx_pin = level;
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_frame(input uart_byte_t b, input logic stop_level);
    drive_bit(1'b0);
    // LSB first
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(stop_level);
    // One idle bit before the next start
    drive_bit(1'b1);
  endtask

  task automatic send_byte(input uart_byte_t b);
    send_frame(b, 1'b1);
  endtask

  // Stop bit held low for a whole bit period
  task automatic send_bad_frame(input uart_byte_t b);
    send_frame(b, 1'b0);
  endtask

endmodule

`default_nettype wire

/* rtl/uart_core.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_core #(
  parameter int CLOCK_FREQ = 100_000_000,
  parameter int BAUD_RATE  = 115_200,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 utx_valid,
  input  uart_pkg::uart_byte_t utx_data,
  output logic                 utx_ready,
  output logic                 urx_valid,
  output uart_pkg::uart_byte_t urx_data,
  input  logic                 urx_ready,
  output logic                 frame_err,
  output logic                 overrun,
  output logic                 utx_pin,
  input  logic                 urx_pin
);
  import uart_pkg::*;

  // Bit period in clocks, rounded down
  localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

  // Mid-bit sampling needs a few clocks per bit
  if (CLKS_PER_BIT < 4) begin : g_bad_baud
    $error("uart_core: CLOCK_FREQ / BAUD_RATE must be at least 4");
  end

  // Receiver to FIFO stream
  logic       rx_valid;
  uart_byte_t rx_data;
  logic       rx_ready;

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .utx_pin  (utx_pin)
  );

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .urx_pin  (urx_pin),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .frame_err(frame_err)
  );

  uart_rx_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready),
    .overrun  (overrun)
  );

endmodule

`default_nettype wire

/* rtl/uart_rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx_valid,
  input  uart_pkg::uart_byte_t rx_data,
  output logic                 rx_ready,
  output logic                 urx_valid,
  output uart_pkg::uart_byte_t urx_data,
  input  logic                 urx_ready,
  output logic                 overrun
);
  import uart_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  uart_byte_t mem [FIFO_DEPTH];
  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] count;
  logic        full;
  logic        wr_en;
  logic        rd_en;

  // Serial line cannot be paused, so never push back
  assign rx_ready  = 1'b1;
  assign count     = wr_ptr - rd_ptr;
  assign full      = (count == (AW + 1)'(FIFO_DEPTH));
  assign urx_valid = (wr_ptr != rd_ptr);
  // Head entry shows straight away
  assign urx_data  = mem[rd_ptr[AW-1:0]];
  assign rd_en     = urx_valid && urx_ready;
  // A read in the same cycle frees the slot for the write
  assign wr_en     = rx_valid && rx_ready && (!full || rd_en);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      overrun <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Incoming byte dropped, stored ones kept
      overrun <= rx_valid && full && !rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= rx_data;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (AW + 1)'(FIFO_DEPTH))
    else $error("uart_rx_fifo: fill count above depth");

  // Head byte must not move under a stalled reader
  a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (urx_valid && !urx_ready) |=> $stable(urx_data))
    else $error("uart_rx_fifo: head byte changed while stalled");

endmodule

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 urx_pin,
  output logic                 rx_valid,
  output uart_pkg::uart_byte_t rx_data,
  input  logic                 rx_ready,
  output logic                 frame_err
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  // Middle of the start bit, counted from the falling edge
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam uart_bit_idx_t    IDX_LAST  = uart_bit_idx_t'(UART_DATA_BITS - 1);

  uart_rx_state_e   state;
  logic [CNT_W-1:0] clk_cnt;
  uart_bit_idx_t    bit_idx;
  uart_byte_t       shift;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             bit_done;
  logic             start_edge;

  assign bit_done   = (clk_cnt == BIT_LAST);
  // Falling edge also means the line was high first
  assign start_edge = rx_prev && !rx_sync;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= urx_pin;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      clk_cnt   <= '0;
      bit_idx   <= '0;
      rx_valid  <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      frame_err <= 1'b0;
      // Hold the byte until the FIFO takes it
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (start_edge) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // A glitch shorter than half a bit is not a start
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_LAST) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            clk_cnt <= '0;
            state   <= RX_IDLE;
            // Good stop bit gives a byte, a low one gives an error
            if (rx_sync) begin
              rx_valid <= 1'b1;
            end else begin
              frame_err <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data arrives LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_done) begin
      shift <= {rx_sync, shift[UART_DATA_BITS-1:1]};
    end
    if (state == RX_STOP && bit_done && rx_sync) begin
      rx_data <= shift;
    end
  end

  // Each frame ends in a byte or an error, never both
  a_valid_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rx_valid && frame_err))
    else $error("uart_rx: byte and framing error in the same cycle");

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 utx_valid,
  input  uart_pkg::uart_byte_t utx_data,
  output logic                 utx_ready,
  output logic                 utx_pin
);
  import uart_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  // Last cycle of a bit period
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam uart_bit_idx_t IDX_LAST = uart_bit_idx_t'(UART_DATA_BITS - 1);

  uart_tx_state_e   state;
  logic [CNT_W-1:0] clk_cnt;
  uart_bit_idx_t    bit_idx;
  uart_byte_t       shift;
  logic             bit_done;

  // Only accept a new byte when the line is idle
  assign utx_ready = (state == TX_IDLE);
  assign bit_done  = (clk_cnt == BIT_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      // Idle line level is high
      utx_pin <= 1'b1;
    end else begin
      // Bit-period counter wraps at the end of every bit
      if (state == TX_IDLE || bit_done) begin
        clk_cnt <= '0;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (utx_valid) begin
            // Start bit goes out on the edge right after acceptance
            state   <= TX_START;
            utx_pin <= 1'b0;
            bit_idx <= '0;
          end
        end
        TX_START: begin
          if (bit_done) begin
            state   <= TX_DATA;
            // LSB first
            utx_pin <= shift[0];
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            if (bit_idx == IDX_LAST) begin
              state   <= TX_STOP;
              utx_pin <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              utx_pin <= shift[0];
            end
          end
        end
        TX_STOP: begin
          // Ready comes back after the full stop bit
          if (bit_done) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Shift register holds the bits still to be sent
  always_ff @(posedge clk) begin
    if (utx_valid && utx_ready) begin
      shift <= utx_data;
    end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
      shift <= shift >> 1;
    end
  end

  // Line must rest high between frames
  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    (state == TX_IDLE) |-> utx_pin)
    else $error("uart_tx: line low while idle");

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // Fixed frame format: 8 data bits, no parity, 1 stop bit
  localparam int UART_DATA_BITS = 8;

  // One character on the serial line or on a byte stream
  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  // Index of the data bit currently on the line
  typedef logic [$clog2(UART_DATA_BITS)-1:0] uart_bit_idx_t;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    // Start bit is being driven low
    TX_START,
    TX_DATA,
    // Stop bit is being driven high
    TX_STOP
  } uart_tx_state_e;

  // Receiver FSM
  typedef enum logic [1:0] {
    // Waiting for a falling edge on the synchronized line
    RX_IDLE,
    // Counting to the middle of the start bit
    RX_START,
    // Sampling data bits at mid-bit
    RX_DATA,
    // Sampling the stop bit
    RX_STOP
  } uart_rx_state_e;

endpackage

`default_nettype wire
